// File: hw/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// datapath width in bits.
`define ALU_WIDTH 32

`define ALU_REGS 16
`define ALU_FLAGS 4

// word address width of the bus, registers sit in the upper half.
`define ALU_ADR_W 5

`endif

// File: hw/alu_pkg.sv
`include "alu_cfg.svh"

package alu_pkg;

    typedef logic [`ALU_WIDTH-1:0] word_t;
    typedef logic flag_t;
    typedef logic [3:0] reg_idx_t;   // register or flag index.

    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_shl   = 4'd2,
        op_shr   = 4'd3,
        op_mov   = 4'd4,
        op_ldlo  = 4'd5,
        op_ldhi  = 4'd6,
        op_ldi   = 4'd7,
        op_cmpeq = 4'd8,
        op_cmplt = 4'd9,
        op_cmpgt = 4'd10,
        op_fnot  = 4'd11,
        op_fand  = 4'd12,
        op_fmov  = 4'd13,
        op_jmp   = 4'd14,
        op_jmpf  = 4'd15
    } opcode_e;

    // command word as written to adr_cmd.
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    ra;
        reg_idx_t    rb;
        logic [15:0] imm;
    } instr_t;

    localparam logic [`ALU_ADR_W-1:0] adr_cmd      = 5'd0;
    localparam logic [`ALU_ADR_W-1:0] adr_flags    = 5'd1;
    localparam logic [`ALU_ADR_W-1:0] adr_pc       = 5'd2;
    localparam logic [`ALU_ADR_W-1:0] adr_reg_base = 5'd16;   // up to 31.

endpackage

// File: hw/alu_issue_if.sv
`timescale 1ns/10ps

interface alu_issue_if;
    import alu_pkg::*;

    // command towards the execute stage.
    logic        valid;
    opcode_e     opcode;
    word_t       a;
    word_t       b;
    flag_t       fa;
    flag_t       fb;
    logic [15:0] imm;
    word_t       pc;

    // registered result back to the slave.
    logic        done;
    word_t       result;
    flag_t       flag_out;
    word_t       pc_next;
    logic        wr_reg;
    logic        wr_flag;

    modport slave (
        output valid, opcode, a, b, fa, fb, imm, pc,
        input  done, result, flag_out, pc_next, wr_reg, wr_flag
    );

    modport exec (
        input  valid, opcode, a, b, fa, fb, imm, pc,
        output done, result, flag_out, pc_next, wr_reg, wr_flag
    );

endinterface

// File: hw/ripple_adder.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module ripple_adder (
    input  alu_pkg::word_t a,
    input  alu_pkg::word_t b,
    input  logic           cin,
    output alu_pkg::word_t sum
);

    logic [`ALU_WIDTH-1:0] carry;   // carry into each bit.

    assign carry[0] = cin;

    for (genvar i = 0; i < `ALU_WIDTH; i++)
    begin : g_bit
        logic p;

        assign p      = a[i] ^ b[i];
        assign sum[i] = p ^ carry[i];

        // the last carry out is not needed.
        if (i < `ALU_WIDTH - 1)
        begin : g_carry
            assign carry[i+1] = (a[i] & b[i]) | (p & carry[i]);
        end
    end

endmodule

// File: hw/alu_exec.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_exec (
    input logic       clock,
    input logic       reset,
    alu_issue_if.exec issue
);
    import alu_pkg::*;

    localparam int sh_w = $clog2(`ALU_WIDTH);

    logic  sub_sel;
    word_t adder_b;
    word_t sum;
    logic  shift_over;
    word_t shl_res;
    word_t shr_res;
    word_t pc_inc;
    word_t result_d;
    flag_t flag_d;
    word_t pc_next_d;

    // subtract is a + ~b + 1 through the same adder.
    assign sub_sel = (issue.opcode == op_sub);
    assign adder_b = sub_sel ? ~issue.b : issue.b;

    ripple_adder adder_i (
        .a   (issue.a),
        .b   (adder_b),
        .cin (sub_sel),
        .sum (sum)
    );

    // shifts fill with ones, so shift the inverse in zeros.
    assign shift_over = |issue.b[`ALU_WIDTH-1:sh_w];
    assign shl_res    = shift_over ? '1 : ~(~issue.a << issue.b[sh_w-1:0]);
    assign shr_res    = shift_over ? '1 : ~(~issue.a >> issue.b[sh_w-1:0]);

    assign pc_inc = issue.pc + word_t'(1);

    always_comb
    begin
        result_d  = '0;
        flag_d    = 1'b0;
        pc_next_d = pc_inc;
        case (issue.opcode)
            op_add,
            op_sub:   result_d = sum;
            op_shl:   result_d = shl_res;
            op_shr:   result_d = shr_res;
            op_mov:   result_d = issue.a;
            op_ldlo:  result_d = {issue.a[`ALU_WIDTH-1:16], issue.imm};
            op_ldhi:  result_d = {issue.imm, issue.a[15:0]};
            op_ldi:   result_d = {{(`ALU_WIDTH-16){1'b0}}, issue.imm};
            op_cmpeq: flag_d = (issue.a == issue.b);
            op_cmplt: flag_d = (issue.a < issue.b);   // unsigned.
            op_cmpgt: flag_d = (issue.a > issue.b);
            op_fnot:  flag_d = ~issue.fa;
            op_fand:  flag_d = issue.fa & issue.fb;
            op_fmov:  flag_d = issue.fa;
            op_jmp:   pc_next_d = issue.a;
            op_jmpf:  pc_next_d = issue.fa ? issue.b : pc_inc;
            default:  result_d = '0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            issue.done    <= 1'b0;
            issue.wr_reg  <= 1'b0;
            issue.wr_flag <= 1'b0;
        end
        else
        begin
            issue.done    <= issue.valid;
            issue.wr_reg  <= issue.valid && !issue.opcode[3];   // opcodes 0 to 7.
            issue.wr_flag <= issue.valid && (issue.opcode inside {[op_cmpeq:op_fmov]});
        end
    end

    always_ff @(posedge clock)
    begin
        if (issue.valid)
        begin
            issue.result   <= result_d;
            issue.flag_out <= flag_d;
            issue.pc_next  <= pc_next_d;
        end
    end

    // the slave holds off a new command until the last one is written back.
    a_no_overlap: assert property (@(posedge clock) disable iff (reset)
        issue.done |-> !issue.valid);

endmodule

// File: hw/alu_regfile.sv
`timescale 1ns/10ps

module alu_regfile #(
    parameter type entry_t = alu_pkg::word_t,
    parameter int  DEPTH   = 16
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              we,
    input  alu_pkg::reg_idx_t waddr,
    input  entry_t            wdata,
    input  alu_pkg::reg_idx_t raddr_a,
    input  alu_pkg::reg_idx_t raddr_b,
    output entry_t            rdata_a,
    output entry_t            rdata_b
);

    localparam int aw = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    entry_t mem [DEPTH];

    // cleared on reset so a fresh unit reads all zero.
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (we)
        begin
            mem[waddr[aw-1:0]] <= wdata;   // upper index bits ignored.
        end
    end

    assign rdata_a = mem[raddr_a[aw-1:0]];
    assign rdata_b = mem[raddr_b[aw-1:0]];

endmodule

// File: hw/alu_bus_slave.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_bus_slave (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`ALU_ADR_W-1:0]  wb_adr,
    input  alu_pkg::word_t         wb_dat_w,
    output alu_pkg::word_t         wb_dat_r,
    output logic                   wb_ack,
    alu_issue_if.slave             issue,
    output alu_pkg::reg_idx_t      reg_raddr_a,
    output alu_pkg::reg_idx_t      reg_raddr_b,
    output alu_pkg::reg_idx_t      flag_raddr_a,
    output alu_pkg::reg_idx_t      flag_raddr_b,
    input  alu_pkg::word_t         reg_rdata_a,
    input  alu_pkg::word_t         reg_rdata_b,
    input  alu_pkg::flag_t         flag_rdata_a,
    input  alu_pkg::flag_t         flag_rdata_b,
    output logic                   reg_we,
    output logic                   flag_we,
    output alu_pkg::reg_idx_t      reg_waddr,
    output alu_pkg::reg_idx_t      flag_waddr,
    output alu_pkg::word_t         reg_wdata,
    output alu_pkg::flag_t         flag_wdata,
    input  logic [`ALU_FLAGS-1:0]  flags_all
);
    import alu_pkg::*;

    typedef enum logic [1:0] {st_idle, st_exec, st_ack} state_t;

    state_t   state;
    instr_t   instr_q;
    word_t    pc_q;
    logic     req;
    logic     reg_hit;
    logic     cmd_hit;
    reg_idx_t bus_idx;

    // new requests are only looked at in idle.
    assign req     = (state == st_idle) && wb_cyc && wb_stb;
    assign reg_hit = (wb_adr >= adr_reg_base);
    assign cmd_hit = wb_we && (wb_adr == adr_cmd);
    assign bus_idx = reg_idx_t'(wb_adr - adr_reg_base);

    // port a serves the bus in idle and operand a during a command.
    assign reg_raddr_a  = (state == st_idle) ? bus_idx : instr_q.ra;
    assign reg_raddr_b  = instr_q.rb;
    assign flag_raddr_a = instr_q.ra;
    assign flag_raddr_b = instr_q.rb;

    assign issue.opcode = instr_q.opcode;
    assign issue.a      = reg_rdata_a;
    assign issue.b      = reg_rdata_b;
    assign issue.fa     = flag_rdata_a;
    assign issue.fb     = flag_rdata_b;
    assign issue.imm    = instr_q.imm;
    assign issue.pc     = pc_q;

    always_comb
    begin
        reg_we    = req && wb_we && reg_hit;
        reg_waddr = bus_idx;
        reg_wdata = wb_dat_w;
        if (state == st_exec)
        begin
            reg_we    = issue.done && issue.wr_reg;   // writeback to rd.
            reg_waddr = instr_q.rd;
            reg_wdata = issue.result;
        end
    end

    // flags are only written by commands.
    assign flag_we    = (state == st_exec) && issue.done && issue.wr_flag;
    assign flag_waddr = instr_q.rd;
    assign flag_wdata = issue.flag_out;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state       <= st_idle;
            wb_ack      <= 1'b0;
            issue.valid <= 1'b0;
            pc_q        <= '0;
        end
        else
        begin
            wb_ack      <= 1'b0;
            issue.valid <= 1'b0;
            case (state)
                st_idle:
                    if (req)
                    begin
                        if (cmd_hit)
                        begin
                            issue.valid <= 1'b1;
                            state       <= st_exec;
                        end
                        else
                        begin
                            wb_ack <= 1'b1;
                            state  <= st_ack;
                        end
                    end
                st_exec:
                    if (issue.done)
                    begin
                        pc_q   <= issue.pc_next;
                        wb_ack <= 1'b1;
                        state  <= st_ack;
                    end
                st_ack:
                    if (!wb_stb)
                        state <= st_idle;   // master has let go.
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (req)
        begin
            if (cmd_hit)
                instr_q <= instr_t'(wb_dat_w);
            if (reg_hit)
                wb_dat_r <= reg_rdata_a;
            else if (wb_adr == adr_flags)
                wb_dat_r <= word_t'(flags_all);
            else if (wb_adr == adr_pc)
                wb_dat_r <= pc_q;
            else
                wb_dat_r <= '0;
        end
    end

    a_ack_in_cycle: assert property (@(posedge clock) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb));

    a_ack_single: assert property (@(posedge clock) disable iff (reset)
        wb_ack |=> !wb_ack);

endmodule

// File: hw/alu_unit_top.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_unit_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`ALU_ADR_W-1:0] wb_adr,
    input  alu_pkg::word_t        wb_dat_w,
    output alu_pkg::word_t        wb_dat_r,
    output logic                  wb_ack
);
    import alu_pkg::*;

    reg_idx_t reg_raddr_a;
    reg_idx_t reg_raddr_b;
    word_t    reg_rdata_a;
    word_t    reg_rdata_b;
    logic     reg_we;
    reg_idx_t reg_waddr;
    word_t    reg_wdata;

    reg_idx_t flag_raddr_a;
    reg_idx_t flag_raddr_b;
    flag_t    flag_rdata_a;
    flag_t    flag_rdata_b;
    logic     flag_we;
    reg_idx_t flag_waddr;
    flag_t    flag_wdata;

    logic [`ALU_FLAGS-1:0] flags_all;

    alu_issue_if issue_i ();

    alu_bus_slave slave_i (
        .clock        (clock),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .issue        (issue_i.slave),
        .reg_raddr_a  (reg_raddr_a),
        .reg_raddr_b  (reg_raddr_b),
        .flag_raddr_a (flag_raddr_a),
        .flag_raddr_b (flag_raddr_b),
        .reg_rdata_a  (reg_rdata_a),
        .reg_rdata_b  (reg_rdata_b),
        .flag_rdata_a (flag_rdata_a),
        .flag_rdata_b (flag_rdata_b),
        .reg_we       (reg_we),
        .flag_we      (flag_we),
        .reg_waddr    (reg_waddr),
        .flag_waddr   (flag_waddr),
        .reg_wdata    (reg_wdata),
        .flag_wdata   (flag_wdata),
        .flags_all    (flags_all)
    );

    alu_exec exec_i (
        .clock (clock),
        .reset (reset),
        .issue (issue_i.exec)
    );

    alu_regfile #(.entry_t(word_t), .DEPTH(`ALU_REGS)) reg_file_i (
        .clock   (clock),
        .reset   (reset),
        .we      (reg_we),
        .waddr   (reg_waddr),
        .wdata   (reg_wdata),
        .raddr_a (reg_raddr_a),
        .raddr_b (reg_raddr_b),
        .rdata_a (reg_rdata_a),
        .rdata_b (reg_rdata_b)
    );

    alu_regfile #(.entry_t(flag_t), .DEPTH(`ALU_FLAGS)) flag_file_i (
        .clock   (clock),
        .reset   (reset),
        .we      (flag_we),
        .waddr   (flag_waddr),
        .wdata   (flag_wdata),
        .raddr_a (flag_raddr_a),
        .raddr_b (flag_raddr_b),
        .rdata_a (flag_rdata_a),
        .rdata_b (flag_rdata_b)
    );

    // all four flags at once for reads of adr_flags.
    for (genvar i = 0; i < `ALU_FLAGS; i++)
    begin : g_flags_all
        assign flags_all[i] = flag_file_i.mem[i];
    end

endmodule

// File: tb/alu_unit_tb.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_unit_tb;
    import alu_pkg::*;

    typedef logic [`ALU_ADR_W-1:0] adr_t;

    localparam int num_rows        = 37;
    localparam int cmd_latency     = 4;   // edges from driving a command to seeing ack.
    localparam int reg_latency     = 2;
    localparam int watchdog_cycles = num_rows * 20 + 50;

    localparam adr_t  adr_r1   = adr_reg_base + adr_t'(1);
    localparam adr_t  adr_r2   = adr_reg_base + adr_t'(2);
    localparam adr_t  adr_r3   = adr_reg_base + adr_t'(3);
    localparam word_t all_ones = '1;

    logic  clock;
    logic  reset;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    adr_t  wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic  wb_ack;

    // stimulus table filled once before the run.
    string  row_name [num_rows];
    word_t  row_a    [num_rows];
    word_t  row_b    [num_rows];
    instr_t row_cmd  [num_rows];
    adr_t   row_adr  [num_rows];
    word_t  row_exp  [num_rows];
    int     row_count;

    // reference state of the unit.
    word_t                 model_regs [`ALU_REGS];
    logic [`ALU_FLAGS-1:0] model_flags;
    word_t                 model_pc;

    logic [31:0] rng_state;

    alu_unit_top alu_unit_top_i (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic instr_t make_cmd(opcode_e op, reg_idx_t rd, reg_idx_t ra, reg_idx_t rb,
                                        logic [15:0] imm);
        instr_t c;
        c.opcode = op;
        c.rd     = rd;
        c.ra     = ra;
        c.rb     = rb;
        c.imm    = imm;
        return c;
    endfunction

    // word commands always take r1 and r2 and write r3.
    function automatic instr_t word_cmd(opcode_e op, logic [15:0] imm);
        return make_cmd(op, 4'd3, 4'd1, 4'd2, imm);
    endfunction

    function automatic instr_t flag_cmd(opcode_e op, reg_idx_t rd, reg_idx_t ra, reg_idx_t rb);
        return make_cmd(op, rd, ra, rb, 16'h0);
    endfunction

    function automatic void execute_reference(instr_t c);
        word_t a;
        word_t b;
        logic  fa;
        logic  fb;
        word_t fill_l;
        word_t fill_r;
        word_t pc_new;
        a      = model_regs[c.ra];
        b      = model_regs[c.rb];
        fa     = model_flags[c.ra[1:0]];
        fb     = model_flags[c.rb[1:0]];
        fill_l = ~(all_ones << b[4:0]);   // ones entering from the right.
        fill_r = ~(all_ones >> b[4:0]);
        pc_new = model_pc + 32'd1;
        case (c.opcode)
            op_add:   model_regs[c.rd] = a + b;
            op_sub:   model_regs[c.rd] = a - b;
            op_shl:   model_regs[c.rd] = (b >= 32) ? all_ones : (a << b[4:0]) | fill_l;
            op_shr:   model_regs[c.rd] = (b >= 32) ? all_ones : (a >> b[4:0]) | fill_r;
            op_mov:   model_regs[c.rd] = a;
            op_ldlo:  model_regs[c.rd] = {a[31:16], c.imm};
            op_ldhi:  model_regs[c.rd] = {c.imm, a[15:0]};
            op_ldi:   model_regs[c.rd] = {16'h0, c.imm};
            op_cmpeq: model_flags[c.rd[1:0]] = (a == b);
            op_cmplt: model_flags[c.rd[1:0]] = (a < b);
            op_cmpgt: model_flags[c.rd[1:0]] = (a > b);
            op_fnot:  model_flags[c.rd[1:0]] = ~fa;
            op_fand:  model_flags[c.rd[1:0]] = fa & fb;
            op_fmov:  model_flags[c.rd[1:0]] = fa;
            op_jmp:   pc_new = a;
            op_jmpf:  pc_new = fa ? b : pc_new;
        endcase
        model_pc = pc_new;
    endfunction

    function automatic word_t read_reference(adr_t adr);
        if (adr >= adr_reg_base)
            return model_regs[reg_idx_t'(adr - adr_reg_base)];
        if (adr == adr_flags)
            return word_t'(model_flags);
        if (adr == adr_pc)
            return model_pc;
        return '0;
    endfunction

    function automatic void add_row(string name, word_t a, word_t b, instr_t c, adr_t adr);
        model_regs[1] = a;   // the row preloads r1 and r2 over the bus.
        model_regs[2] = b;
        execute_reference(c);
        if (row_count < num_rows)
        begin
            row_name[row_count] = name;
            row_a[row_count]    = a;
            row_b[row_count]    = b;
            row_cmd[row_count]  = c;
            row_adr[row_count]  = adr;
            row_exp[row_count]  = read_reference(adr);
        end
        row_count++;
    endfunction

    function automatic void build_table();
        word_t rand_a;
        word_t rand_b;
        for (int i = 0; i < `ALU_REGS; i++)
            model_regs[i] = '0;
        model_flags = '0;
        model_pc    = '0;
        row_count   = 0;

        add_row("add_wrap", 32'hffff_ffff, 32'h1, word_cmd(op_add, 16'h0), adr_r3);
        add_row("sub_borrow", 32'h0, 32'h1, word_cmd(op_sub, 16'h0), adr_r3);
        add_row("sub_pos", 32'd10, 32'd3, word_cmd(op_sub, 16'h0), adr_r3);
        add_row("shl_zero", 32'h8000_0001, 32'd0, word_cmd(op_shl, 16'h0), adr_r3);
        add_row("shl_31", 32'h2, 32'd31, word_cmd(op_shl, 16'h0), adr_r3);
        add_row("shr_31", 32'h4000_0000, 32'd31, word_cmd(op_shr, 16'h0), adr_r3);
        add_row("shl_over", 32'h1234, 32'd32, word_cmd(op_shl, 16'h0), adr_r3);
        add_row("shr_over", 32'h1234, 32'h100, word_cmd(op_shr, 16'h0), adr_r3);
        for (int i = 0; i < 2; i++)
        begin
            rand_a = next_rand();
            rand_b = next_rand();
            add_row("add_rand", rand_a, rand_b, word_cmd(op_add, 16'h0), adr_r3);
            add_row("sub_rand", rand_a, rand_b, word_cmd(op_sub, 16'h0), adr_r3);
            add_row("shl_rand", rand_a, rand_b & 32'h1f, word_cmd(op_shl, 16'h0), adr_r3);
            add_row("shr_rand", rand_b, rand_a & 32'h1f, word_cmd(op_shr, 16'h0), adr_r3);
        end
        add_row("mov", 32'hdead_beef, 32'h0, word_cmd(op_mov, 16'h0), adr_r3);
        add_row("ldlo", 32'hdead_beef, 32'h0, word_cmd(op_ldlo, 16'h1234), adr_r3);
        add_row("ldhi", 32'hdead_beef, 32'h0, word_cmd(op_ldhi, 16'h1234), adr_r3);
        add_row("ldi", 32'hffff_ffff, 32'h0, word_cmd(op_ldi, 16'h8001), adr_r3);
        add_row("cmpeq_eq", 32'd7, 32'd7, flag_cmd(op_cmpeq, 4'd0, 4'd1, 4'd2), adr_flags);
        add_row("cmpeq_ne", 32'd1, 32'd2, flag_cmd(op_cmpeq, 4'd3, 4'd1, 4'd2), adr_flags);
        add_row("cmplt_lo", 32'd3, 32'd9, flag_cmd(op_cmplt, 4'd1, 4'd1, 4'd2), adr_flags);
        add_row("cmplt_eq", 32'd5, 32'd5, flag_cmd(op_cmplt, 4'd2, 4'd1, 4'd2), adr_flags);
        add_row("cmpgt_hi", all_ones, 32'd1, flag_cmd(op_cmpgt, 4'd2, 4'd1, 4'd2), adr_flags);
        add_row("cmpgt_lo", 32'd1, all_ones, flag_cmd(op_cmpgt, 4'd3, 4'd1, 4'd2), adr_flags);
        add_row("fnot_set", 32'd0, 32'd0, flag_cmd(op_fnot, 4'd3, 4'd3, 4'd0), adr_flags);
        add_row("fnot_clr", 32'd0, 32'd0, flag_cmd(op_fnot, 4'd0, 4'd0, 4'd0), adr_flags);
        add_row("fand", 32'd0, 32'd0, flag_cmd(op_fand, 4'd2, 4'd0, 4'd1), adr_flags);
        add_row("fmov", 32'd0, 32'd0, flag_cmd(op_fmov, 4'd0, 4'd1, 4'd0), adr_flags);
        add_row("pc_step", 32'd1, 32'd1, word_cmd(op_add, 16'h0), adr_pc);
        add_row("jmp", 32'h100, 32'd0, word_cmd(op_jmp, 16'h0), adr_pc);
        add_row("pc_after_jmp", 32'd1, 32'd1, word_cmd(op_add, 16'h0), adr_pc);
        add_row("flag_set", 32'd4, 32'd4, flag_cmd(op_cmpeq, 4'd1, 4'd1, 4'd2), adr_flags);
        add_row("jmpf_taken", 32'd0, 32'h200, flag_cmd(op_jmpf, 4'd0, 4'd1, 4'd2), adr_pc);
        add_row("flag_clr", 32'd4, 32'd4, flag_cmd(op_cmplt, 4'd1, 4'd1, 4'd2), adr_flags);
        add_row("jmpf_not", 32'd0, 32'h300, flag_cmd(op_jmpf, 4'd0, 4'd1, 4'd2), adr_pc);
    endfunction

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_word(string name, word_t exp, word_t act);
        if (act !== exp)
        begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_flags(string name, logic [`ALU_FLAGS-1:0] exp,
                                 logic [`ALU_FLAGS-1:0] act);
        if (act !== exp)
        begin
            $display("[FAIL] %s expected flags %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // called right after a rising edge; returns right after one.
    task automatic wishbone_cycle(input string name, input logic we, input adr_t adr,
                                  input word_t wdata, input int exp_latency,
                                  output word_t rdata);
        int latency;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(posedge clock);
        latency = 1;
        while (!wb_ack)
        begin
            @(posedge clock);
            latency++;
        end
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (latency != exp_latency)
        begin
            $display("[FAIL] %s ack latency expected %0d actual %0d", name, exp_latency, latency);
            abort_run();
        end
        @(posedge clock);
        if (wb_ack)
        begin
            $display("%s request got a second ack cycle", name);
            abort_run();
        end
    endtask

    task automatic write_word(string name, adr_t adr, word_t data);
        word_t ignored;
        wishbone_cycle(name, 1'b1, adr, data,
                       (adr == adr_cmd) ? cmd_latency : reg_latency, ignored);
    endtask

    task automatic read_word(string name, adr_t adr, output word_t data);
        wishbone_cycle(name, 1'b0, adr, '0, reg_latency, data);
    endtask

    initial
    begin
        word_t data;
        word_t value;
        rng_state = 32'hd7e1_7380;
        build_table();
        if (row_count != num_rows)
        begin
            $display("stimulus table holds %0d rows instead of %0d", row_count, num_rows);
            abort_run();
        end

        reset    <= 1'b1;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < `ALU_REGS; i++)
        begin
            read_word($sformatf("reset r%0d", i), adr_reg_base + adr_t'(i), data);
            compare_word($sformatf("reset r%0d", i), '0, data);
        end
        read_word("reset flags", adr_flags, data);
        compare_word("reset flags", '0, data);
        read_word("reset pc", adr_pc, data);
        compare_word("reset pc", '0, data);

        value = next_rand();
        write_word("write r5", adr_reg_base + adr_t'(5), value);
        read_word("read r5", adr_reg_base + adr_t'(5), data);
        compare_word("read r5", value, data);
        write_word("write r15", adr_reg_base + adr_t'(15), 32'ha5a5_5a5a);
        read_word("read r15", adr_reg_base + adr_t'(15), data);
        compare_word("read r15", 32'ha5a5_5a5a, data);

        for (int i = 0; i < num_rows; i++)
        begin
            write_word({row_name[i], " load a"}, adr_r1, row_a[i]);
            write_word({row_name[i], " load b"}, adr_r2, row_b[i]);
            write_word(row_name[i], adr_cmd, word_t'(row_cmd[i]));
            read_word(row_name[i], row_adr[i], data);
            if (row_adr[i] == adr_flags)
                compare_flags(row_name[i], row_exp[i][`ALU_FLAGS-1:0], data[`ALU_FLAGS-1:0]);
            else
                compare_word(row_name[i], row_exp[i], data);
        end

        // read-only addresses take the write and keep their value.
        write_word("write flags", adr_flags, all_ones);
        read_word("flags after write", adr_flags, data);
        compare_flags("flags after write", model_flags, data[`ALU_FLAGS-1:0]);
        write_word("write pc", adr_pc, 32'h1234);
        read_word("pc after write", adr_pc, data);
        compare_word("pc after write", model_pc, data);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+hw
hw/alu_pkg.sv
hw/alu_issue_if.sv
hw/ripple_adder.sv
hw/alu_exec.sv
hw/alu_regfile.sv
hw/alu_bus_slave.sv
hw/alu_unit_top.sv
tb/alu_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f sim.f \
    --top-module alu_unit_tb \
    --Mdir obj_dir

status=0
output=$(./obj_dir/Valu_unit_tb 2>&1) || status=$?
echo "$output"

if grep -qx "Verification passed" <<< "$output"; then
    exit 0
fi
echo "simulation did not pass (exit status ${status})"
exit 1
